/* flist.f */
+incdir+include
hw/decode_pkg.sv
hw/branch_decode.sv
hw/arith_decode.sv
hw/lsu_decode.sv
hw/decode_stage.sv
hw/decoder_top.sv
testbench/decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module decoder_tb

out=$(./obj_dir/Vdecoder_tb || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* testbench/decoder_tb.sv */
`timescale 1ns/1ps
`include "decode_config.svh"

module decoder_tb;

    localparam int ACK_TIMEOUT = 20;
    localparam int STREAM_LEN = 300;

    typedef struct packed {
        logic                     err;
        decode_pkg::decode_info_t info;
    } expect_t;

    logic                     clk;
    logic                     rst_n_i;
    logic                     req_i;
    decode_pkg::inst_t        inst_i;
    logic                     ack_o;
    logic                     decode_err_o;
    decode_pkg::decode_info_t info_o;

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          err_mark;
    bit          timed_out;
    bit          ack_prev;
    expect_t     exp_q[$];
    int unsigned op_len[$];
    logic [31:0] op_pat[$];

    decoder_top DUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .inst_i       (inst_i),
        .ack_o        (ack_o),
        .decode_err_o (decode_err_o),
        .info_o       (info_o)
    );

    always #2 clk = ~clk;

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] want);
        checks++;
        if (got !== want) begin
            $display("** Error: %s is %0h, expected %0h at %0t", name, got, want, $time);
            errors++;
        end
    endtask

    function automatic decode_pkg::decode_info_t alu_expect(
        input decode_pkg::inst_t      inst,
        input decode_pkg::alu_gtype_e gtype,
        input decode_pkg::alu_op_t    op,
        input decode_pkg::reg_r0_e    r0,
        input decode_pkg::imm_e       imm
    );
        decode_pkg::decode_info_t info;
        info = '0;
        info.alu_inst = 1'b1;
        info.reg_type_r0 = r0;
        info.reg_type_r1 = decode_pkg::REG_R1_RJ;
        info.reg_type_w = decode_pkg::REG_W_RD;
        info.imm_type = imm;
        info.alu_grand_op = gtype;
        info.alu_op = op;
        info.inst = inst;
        return info;
    endfunction

    function automatic expect_t ref_decode(input decode_pkg::inst_t inst);
        expect_t     e;
        logic [5:0]  op6;
        logic [6:0]  op7;
        logic [9:0]  op10;
        logic [16:0] op17;
        logic        store;
        op6 = inst[31:26];
        op7 = inst[31:25];
        op10 = inst[31:22];
        op17 = inst[31:15];
        e = '0;
        e.info.inst = inst;
        if (op6 >= 6'h13 && op6 <= 6'h1b) begin
            e.info.alu_inst = 1'b1;
            e.info.jump_inst = 1'b1;
            e.info.slot0 = 1'b1;
            if (op6 == 6'h13) begin
                // JIRL
                e.info.reg_type_r1 = decode_pkg::REG_R1_RJ;
                e.info.reg_type_w = decode_pkg::REG_W_RD;
                e.info.addr_imm_type = decode_pkg::ADDR_IMM_S16;
                e.info.target_type = decode_pkg::TARGET_ABS;
                e.info.alu_grand_op = decode_pkg::ALU_GTYPE_LI;
                e.info.alu_op = `ALU_STYPE_PCPLUS4;
            end else if (op6 == 6'h14 || op6 == 6'h15) begin
                e.info.addr_imm_type = decode_pkg::ADDR_IMM_S26;
                if (op6 == 6'h15) begin
                    e.info.reg_type_w = decode_pkg::REG_W_BL1;
                    e.info.alu_grand_op = decode_pkg::ALU_GTYPE_LI;
                    e.info.alu_op = `ALU_STYPE_PCPLUS4;
                end
            end else begin
                // BEQ to BGEU follow the order of cmp_e
                e.info.reg_type_r0 = decode_pkg::REG_R0_RD;
                e.info.reg_type_r1 = decode_pkg::REG_R1_RJ;
                e.info.addr_imm_type = decode_pkg::ADDR_IMM_S16;
                e.info.cmp_type = decode_pkg::cmp_e'(op6[3:0] - 4'd5);
            end
        end else if (op7 == 7'h0a || op7 == 7'h0e) begin
            e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_LI,
                                (op7 == 7'h0a) ? `ALU_STYPE_LUI : `ALU_STYPE_PCADDUI,
                                decode_pkg::REG_R0_IMM, decode_pkg::IMM_S20);
            // LU12I and PCADDU12I take no register source
            e.info.reg_type_r1 = decode_pkg::REG_R1_NONE;
        end else if (op10 inside {10'h008, 10'h009, 10'h00a}) begin
            e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_INT,
                                (op10 == 10'h008) ? `ALU_STYPE_SLT :
                                (op10 == 10'h009) ? `ALU_STYPE_SLTU : `ALU_STYPE_ADD,
                                decode_pkg::REG_R0_IMM, decode_pkg::IMM_S12);
        end else if (op10 inside {10'h00d, 10'h00e, 10'h00f}) begin
            e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_BW, op10[1:0],
                                decode_pkg::REG_R0_IMM, decode_pkg::IMM_U12);
        end else if (op10 inside {10'h0a0, 10'h0a1, 10'h0a2, 10'h0a4, 10'h0a5, 10'h0a6,
                                  10'h0a8, 10'h0a9}) begin
            store = op10[2];
            e.info.lsu_inst = 1'b1;
            e.info.mem_read = !store;
            e.info.mem_write = store;
            e.info.reg_type_r0 = store ? decode_pkg::REG_R0_RD : decode_pkg::REG_R0_NONE;
            e.info.reg_type_r1 = decode_pkg::REG_R1_RJ;
            e.info.reg_type_w = store ? decode_pkg::REG_W_NONE : decode_pkg::REG_W_RD;
            e.info.addr_imm_type = decode_pkg::ADDR_IMM_S12;
            if (op10[3]) begin
                e.info.mem_type = op10[0] ? decode_pkg::MEM_UHALF : decode_pkg::MEM_UBYTE;
            end else begin
                e.info.mem_type = decode_pkg::mem_type_e'({1'b0, op10[1:0]});
            end
        end else begin
            case (op17)
                17'h20: e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_ADD,
                                            decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h22: e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SUB,
                                            decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h24: e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SLT,
                                            decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h25: e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SLTU,
                                            decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h28, 17'h29, 17'h2a, 17'h2b:
                    e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_BW, op17[1:0],
                                        decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h2e: e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SLL,
                                            decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h2f: e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SRL,
                                            decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h30: e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SRA,
                                            decode_pkg::REG_R0_RK, decode_pkg::IMM_U5);
                17'h38, 17'h39, 17'h3a, 17'h40, 17'h41, 17'h42, 17'h43: begin
                    // Divides sit at 0x40 and up
                    e.info.mul_inst = !op17[6];
                    e.info.div_inst = op17[6];
                    e.info.reg_type_r0 = decode_pkg::REG_R0_RK;
                    e.info.reg_type_r1 = decode_pkg::REG_R1_RJ;
                    e.info.reg_type_w = decode_pkg::REG_W_RD;
                    e.info.alu_op = op17[1:0];
                end
                17'h81, 17'h89, 17'h91:
                    e.info = alu_expect(inst, decode_pkg::ALU_GTYPE_SFT, op17[4:3],
                                        decode_pkg::REG_R0_IMM, decode_pkg::IMM_U5);
                default: e.err = 1'b1;
            endcase
        end
        return e;
    endfunction

    function automatic expect_t error_expect(input decode_pkg::inst_t inst);
        expect_t e;
        e = '0;
        e.err = 1'b1;
        e.info.inst = inst;
        return e;
    endfunction

    task automatic add_op(input int unsigned len, input logic [31:0] pat);
        op_len.push_back(len);
        op_pat.push_back(pat);
    endtask

    // Kept opcodes as a prefix length and the prefix value
    task automatic init_table();
        for (int i = 'h13; i <= 'h1b; i++) begin
            add_op(6, 32'(i));
        end
        add_op(7, 32'h0a);
        add_op(7, 32'h0e);
        add_op(10, 32'h008);
        add_op(10, 32'h009);
        add_op(10, 32'h00a);
        add_op(10, 32'h00d);
        add_op(10, 32'h00e);
        add_op(10, 32'h00f);
        add_op(10, 32'h0a0);
        add_op(10, 32'h0a1);
        add_op(10, 32'h0a2);
        add_op(10, 32'h0a4);
        add_op(10, 32'h0a5);
        add_op(10, 32'h0a6);
        add_op(10, 32'h0a8);
        add_op(10, 32'h0a9);
        add_op(17, 32'h20);
        add_op(17, 32'h22);
        add_op(17, 32'h24);
        add_op(17, 32'h25);
        for (int i = 'h28; i <= 'h2b; i++) begin
            add_op(17, 32'(i));
        end
        add_op(17, 32'h2e);
        add_op(17, 32'h2f);
        add_op(17, 32'h30);
        for (int i = 'h38; i <= 'h3a; i++) begin
            add_op(17, 32'(i));
        end
        for (int i = 'h40; i <= 'h43; i++) begin
            add_op(17, 32'(i));
        end
        add_op(17, 32'h81);
        add_op(17, 32'h89);
        add_op(17, 32'h91);
    endtask

    function automatic decode_pkg::inst_t make_inst(input int k);
        logic [31:0] rnd;
        logic [31:0] mask;
        rnd = $urandom;
        mask = 32'hffff_ffff >> op_len[k];
        return (op_pat[k] << (32 - op_len[k])) | (rnd & mask);
    endfunction

    function automatic int pick_op();
        return $urandom_range(0, op_pat.size() - 1);
    endfunction

    // Called on a falling edge with ack_o low
    task automatic start_request(input decode_pkg::inst_t inst, input expect_t exp);
        int n;
        exp_q.push_back(exp);
        req_i = 1'b1;
        inst_i = inst;
        for (n = 0; n < ACK_TIMEOUT && !ack_o; n++) begin
            @(negedge clk);
        end
        if (!ack_o) begin
            $display("Timeout: ack_o never rose for instruction %h", inst);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic end_request();
        int n;
        req_i = 1'b0;
        for (n = 0; n < ACK_TIMEOUT && ack_o; n++) begin
            @(negedge clk);
        end
        if (ack_o) begin
            $display("Timeout: ack_o stayed high after req_i was dropped");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic request(input decode_pkg::inst_t inst, input expect_t exp);
        start_request(inst, exp);
        if (!timed_out) begin
            end_request();
        end
    endtask

    // Compares each captured result on the falling edge after ack_o rises
    always @(negedge clk) begin
        if (rst_n_i && ack_o && !ack_prev) begin
            if (exp_q.size() == 0) begin
                $display("ack_o rose with no request outstanding");
                errors++;
            end else begin
                expect_t exp;
                exp = exp_q.pop_front();
                check_val("decode_err_o", 128'(decode_err_o), 128'(exp.err));
                check_val("info_o", 128'(info_o), 128'(exp.info));
            end
        end
        ack_prev = ack_o;
    end

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic test_dropped();
        decode_pkg::inst_t dropped[7];
        logic [31:0]       rnd;
        expect_t           probe;
        int                n;
        rnd = $urandom;
        dropped[0] = {8'h04, rnd[13:0], 5'd0, rnd[18:14]};
        dropped[1] = 32'h0648_2800;
        dropped[2] = 32'h0648_3800;
        dropped[3] = {17'h00056, rnd[14:0]};
        dropped[4] = {8'h20, rnd[13:0], rnd[18:14], rnd[23:19]};
        dropped[5] = {17'h070e4, rnd[14:0]};
        dropped[6] = $urandom;
        probe = ref_decode(dropped[6]);
        for (n = 0; n < 1000 && !probe.err; n++) begin
            dropped[6] = $urandom;
            probe = ref_decode(dropped[6]);
        end
        for (int i = 0; i < 7 && !timed_out; i++) begin
            request(dropped[i], error_expect(dropped[i]));
        end
        end_test("dropped instructions");
    endtask

    task automatic test_hold();
        decode_pkg::inst_t inst;
        expect_t           exp;
        logic [31:0]       rnd;
        int                extra;
        inst = make_inst(pick_op());
        exp = ref_decode(inst);
        start_request(inst, exp);
        extra = $urandom_range(1, 10);
        for (int i = 0; i < extra && !timed_out; i++) begin
            rnd = $urandom;
            inst_i = rnd;
            @(negedge clk);
            check_val("ack_o", 128'(ack_o), 128'(1'b1));
            check_val("decode_err_o", 128'(decode_err_o), 128'(exp.err));
            check_val("info_o", 128'(info_o), 128'(exp.info));
        end
        if (!timed_out) begin
            end_request();
        end
        end_test("hold while req_i high");
    endtask

    initial begin
        decode_pkg::inst_t inst;
        clk = 1'b0;
        rst_n_i = 1'b0;
        req_i = 1'b0;
        inst_i = '0;
        void'($urandom(78));
        init_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        check_val("ack_o", 128'(ack_o), 128'(1'b0));
        check_val("decode_err_o", 128'(decode_err_o), 128'(1'b0));
        check_val("info_o", 128'(info_o), 128'(0));
        end_test("reset values");

        for (int k = 0; k < op_pat.size() && !timed_out; k++) begin
            inst = make_inst(k);
            request(inst, ref_decode(inst));
        end
        end_test("kept opcodes");

        if (!timed_out) begin
            test_dropped();
        end
        if (!timed_out) begin
            test_hold();
        end

        for (int i = 0; i < 2 && !timed_out; i++) begin
            inst = make_inst(pick_op());
            request(inst, ref_decode(inst));
        end
        end_test("release and next request");

        for (int i = 0; i < STREAM_LEN && !timed_out; i++) begin
            if ($urandom_range(0, 9) < 8) begin
                inst = make_inst(pick_op());
            end else begin
                inst = $urandom;
            end
            request(inst, ref_decode(inst));
        end
        end_test("random stream");

        if (!timed_out && exp_q.size() != 0) begin
            $display("%0d expected results were never compared", exp_q.size());
            errors++;
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* hw/decoder_top.sv */
`timescale 1ns/1ps

module decoder_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     req_i,
    input  decode_pkg::inst_t        inst_i,
    output logic                     ack_o,
    output logic                     decode_err_o,
    output decode_pkg::decode_info_t info_o
);

    decode_pkg::class_decode_t branch_res;
    decode_pkg::class_decode_t arith_res;
    decode_pkg::class_decode_t lsu_res;

    // Class decoders run every cycle, the stage samples them on capture
    branch_decode u_branch_decode (
        .inst_i (inst_i),
        .res_o  (branch_res)
    );

    arith_decode u_arith_decode (
        .inst_i (inst_i),
        .res_o  (arith_res)
    );

    lsu_decode u_lsu_decode (
        .inst_i (inst_i),
        .res_o  (lsu_res)
    );

    decode_stage u_decode_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .inst_i       (inst_i),
        .branch_i     (branch_res),
        .arith_i      (arith_res),
        .lsu_i        (lsu_res),
        .ack_o        (ack_o),
        .decode_err_o (decode_err_o),
        .info_o       (info_o)
    );

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  decode_pkg::inst_t         inst_i,
    input  decode_pkg::class_decode_t branch_i,
    input  decode_pkg::class_decode_t arith_i,
    input  decode_pkg::class_decode_t lsu_i,
    output logic                      ack_o,
    output logic                      decode_err_o,
    output decode_pkg::decode_info_t  info_o
);

    decode_pkg::stage_state_e state_q;
    decode_pkg::stage_state_e state_d;
    decode_pkg::decode_info_t sel_info;
    decode_pkg::decode_info_t info_q;
    logic                     any_hit;
    logic                     capture;
    logic                     err_q;

    // A new request is taken only from IDLE
    assign capture = (state_q == decode_pkg::STAGE_IDLE) && req_i;

    always_comb begin
        any_hit = 1'b1;
        case ({branch_i.hit, arith_i.hit, lsu_i.hit})
            3'b100:  sel_info = branch_i.info;
            3'b010:  sel_info = arith_i.info;
            3'b001:  sel_info = lsu_i.info;
            default: begin
                sel_info = '0;
                any_hit = 1'b0;
            end
        endcase
        sel_info.inst = inst_i;
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            decode_pkg::STAGE_IDLE: begin
                if (req_i) begin
                    state_d = decode_pkg::STAGE_ACK;
                end
            end
            decode_pkg::STAGE_ACK: begin
                if (!req_i) begin
                    state_d = decode_pkg::STAGE_IDLE;
                end
            end
            default: state_d = decode_pkg::STAGE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= decode_pkg::STAGE_IDLE;
            info_q <= '0;
            err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                info_q <= sel_info;
                err_q <= !any_hit;
            end
        end
    end

    assign ack_o = (state_q == decode_pkg::STAGE_ACK);
    assign decode_err_o = err_q;
    assign info_o = info_q;

    // Class decoders own disjoint opcode sets
    a_one_class: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i |-> $onehot0({branch_i.hit, arith_i.hit, lsu_i.hit}))
        else $error("more than one class decoder hit, inst %h", inst_i);

    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack rose without a pending request");

endmodule

/* hw/lsu_decode.sv */
`timescale 1ns/1ps

module lsu_decode (
    input  decode_pkg::inst_t         inst_i,
    output decode_pkg::class_decode_t res_o
);

    localparam logic [9:0] OP_LD_B  = 10'b0010100000;
    localparam logic [9:0] OP_LD_H  = 10'b0010100001;
    localparam logic [9:0] OP_LD_W  = 10'b0010100010;
    localparam logic [9:0] OP_ST_B  = 10'b0010100100;
    localparam logic [9:0] OP_ST_H  = 10'b0010100101;
    localparam logic [9:0] OP_ST_W  = 10'b0010100110;
    localparam logic [9:0] OP_LD_BU = 10'b0010101000;
    localparam logic [9:0] OP_LD_HU = 10'b0010101001;

    logic                  hit;
    logic                  store;
    decode_pkg::mem_type_e acc_type;

    always_comb begin
        hit = 1'b1;
        store = 1'b0;
        acc_type = decode_pkg::MEM_BYTE;
        unique case (inst_i[31:22])
            OP_LD_B:  acc_type = decode_pkg::MEM_BYTE;
            OP_LD_H:  acc_type = decode_pkg::MEM_HALF;
            OP_LD_W:  acc_type = decode_pkg::MEM_WORD;
            OP_LD_BU: acc_type = decode_pkg::MEM_UBYTE;
            OP_LD_HU: acc_type = decode_pkg::MEM_UHALF;
            OP_ST_B:  store = 1'b1;
            OP_ST_H: begin
                store = 1'b1;
                acc_type = decode_pkg::MEM_HALF;
            end
            OP_ST_W: begin
                store = 1'b1;
                acc_type = decode_pkg::MEM_WORD;
            end
            default: hit = 1'b0;
        endcase
    end

    // Address is rj plus si12; stores take their data from rd
    always_comb begin
        res_o = '0;
        if (hit) begin
            res_o.hit = 1'b1;
            res_o.info.lsu_inst = 1'b1;
            res_o.info.reg_type_r0 = store ? decode_pkg::REG_R0_RD : decode_pkg::REG_R0_NONE;
            res_o.info.reg_type_r1 = decode_pkg::REG_R1_RJ;
            res_o.info.reg_type_w = store ? decode_pkg::REG_W_NONE : decode_pkg::REG_W_RD;
            res_o.info.addr_imm_type = decode_pkg::ADDR_IMM_S12;
            res_o.info.mem_type = acc_type;
            res_o.info.mem_read = !store;
            res_o.info.mem_write = store;
        end
    end

    always_comb begin
        assert (!(res_o.info.mem_read && res_o.info.mem_write))
            else $error("lsu_decode flagged both read and write, inst %h", inst_i);
    end

endmodule

/* hw/arith_decode.sv */
`timescale 1ns/1ps
`include "decode_config.svh"

module arith_decode (
    input  decode_pkg::inst_t         inst_i,
    output decode_pkg::class_decode_t res_o
);

    // Immediate forms read rj, except the load-immediate group
    function automatic decode_pkg::class_decode_t ri_res(
        input decode_pkg::alu_gtype_e gtype,
        input decode_pkg::alu_op_t    op,
        input decode_pkg::imm_e       imm
    );
        decode_pkg::class_decode_t res;
        res = '0;
        res.hit = 1'b1;
        res.info.alu_inst = 1'b1;
        res.info.reg_type_r0 = decode_pkg::REG_R0_IMM;
        res.info.reg_type_r1 = (gtype == decode_pkg::ALU_GTYPE_LI) ? decode_pkg::REG_R1_NONE
                                                                   : decode_pkg::REG_R1_RJ;
        res.info.reg_type_w = decode_pkg::REG_W_RD;
        res.info.imm_type = imm;
        res.info.alu_grand_op = gtype;
        res.info.alu_op = op;
        return res;
    endfunction

    function automatic decode_pkg::class_decode_t rr_res(
        input decode_pkg::alu_gtype_e gtype,
        input decode_pkg::alu_op_t    op
    );
        decode_pkg::class_decode_t res;
        res = ri_res(gtype, op, decode_pkg::IMM_U5);
        res.info.reg_type_r0 = decode_pkg::REG_R0_RK;
        return res;
    endfunction

    function automatic decode_pkg::class_decode_t mdu_res(
        input logic                is_div,
        input decode_pkg::alu_op_t op
    );
        decode_pkg::class_decode_t res;
        res = '0;
        res.hit = 1'b1;
        res.info.mul_inst = !is_div;
        res.info.div_inst = is_div;
        res.info.reg_type_r0 = decode_pkg::REG_R0_RK;
        res.info.reg_type_r1 = decode_pkg::REG_R1_RJ;
        res.info.reg_type_w = decode_pkg::REG_W_RD;
        res.info.alu_op = op;
        return res;
    endfunction

    always_comb begin
        unique casez (inst_i[31:15])
            17'b0001010??????????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_LI, `ALU_STYPE_LUI, decode_pkg::IMM_S20);
            17'b0001110??????????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_LI, `ALU_STYPE_PCADDUI, decode_pkg::IMM_S20);
            17'b0000001000???????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SLT, decode_pkg::IMM_S12);
            17'b0000001001???????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SLTU, decode_pkg::IMM_S12);
            17'b0000001010???????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_ADD, decode_pkg::IMM_S12);
            17'b0000001101???????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_BW, `ALU_STYPE_AND, decode_pkg::IMM_U12);
            17'b0000001110???????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_BW, `ALU_STYPE_OR, decode_pkg::IMM_U12);
            17'b0000001111???????:
                res_o = ri_res(decode_pkg::ALU_GTYPE_BW, `ALU_STYPE_XOR, decode_pkg::IMM_U12);
            17'b00000000000100000: res_o = rr_res(decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_ADD);
            17'b00000000000100010: res_o = rr_res(decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SUB);
            17'b00000000000100100: res_o = rr_res(decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SLT);
            17'b00000000000100101: res_o = rr_res(decode_pkg::ALU_GTYPE_INT, `ALU_STYPE_SLTU);
            17'b00000000000101000: res_o = rr_res(decode_pkg::ALU_GTYPE_BW, `ALU_STYPE_NOR);
            17'b00000000000101001: res_o = rr_res(decode_pkg::ALU_GTYPE_BW, `ALU_STYPE_AND);
            17'b00000000000101010: res_o = rr_res(decode_pkg::ALU_GTYPE_BW, `ALU_STYPE_OR);
            17'b00000000000101011: res_o = rr_res(decode_pkg::ALU_GTYPE_BW, `ALU_STYPE_XOR);
            17'b00000000000101110: res_o = rr_res(decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SLL);
            17'b00000000000101111: res_o = rr_res(decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SRL);
            17'b00000000000110000: res_o = rr_res(decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SRA);
            17'b00000000000111000: res_o = mdu_res(1'b0, `MDU_TYPE_MULL);
            17'b00000000000111001: res_o = mdu_res(1'b0, `MDU_TYPE_MULH);
            17'b00000000000111010: res_o = mdu_res(1'b0, `MDU_TYPE_MULHU);
            17'b00000000001000000: res_o = mdu_res(1'b1, `MDU_TYPE_DIV);
            17'b00000000001000001: res_o = mdu_res(1'b1, `MDU_TYPE_MOD);
            17'b00000000001000010: res_o = mdu_res(1'b1, `MDU_TYPE_DIVU);
            17'b00000000001000011: res_o = mdu_res(1'b1, `MDU_TYPE_MODU);
            // Shift by 5-bit immediate
            17'b00000000010000001:
                res_o = ri_res(decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SLL, decode_pkg::IMM_U5);
            17'b00000000010001001:
                res_o = ri_res(decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SRL, decode_pkg::IMM_U5);
            17'b00000000010010001:
                res_o = ri_res(decode_pkg::ALU_GTYPE_SFT, `ALU_STYPE_SRA, decode_pkg::IMM_U5);
            default: res_o = '0;
        endcase
    end

    always_comb begin
        assert (!(res_o.info.mul_inst && res_o.info.div_inst))
            else $error("arith_decode flagged both multiply and divide, inst %h", inst_i);
    end

endmodule

/* hw/branch_decode.sv */
`timescale 1ns/1ps
`include "decode_config.svh"

module branch_decode (
    input  decode_pkg::inst_t         inst_i,
    output decode_pkg::class_decode_t res_o
);

    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;
    localparam logic [5:0] OP_BEQ  = 6'b010110;
    localparam logic [5:0] OP_BNE  = 6'b010111;
    localparam logic [5:0] OP_BLT  = 6'b011000;
    localparam logic [5:0] OP_BGE  = 6'b011001;
    localparam logic [5:0] OP_BLTU = 6'b011010;
    localparam logic [5:0] OP_BGEU = 6'b011011;

    always_comb begin
        // Common shape is a conditional branch comparing rd with rj
        res_o = '0;
        res_o.hit = 1'b1;
        res_o.info.alu_inst = 1'b1;
        res_o.info.jump_inst = 1'b1;
        res_o.info.slot0 = 1'b1;
        res_o.info.reg_type_r0 = decode_pkg::REG_R0_RD;
        res_o.info.reg_type_r1 = decode_pkg::REG_R1_RJ;
        res_o.info.addr_imm_type = decode_pkg::ADDR_IMM_S16;
        res_o.info.target_type = decode_pkg::TARGET_REL;
        unique case (inst_i[31:26])
            OP_JIRL: begin
                res_o.info.reg_type_r0 = decode_pkg::REG_R0_NONE;
                res_o.info.reg_type_w = decode_pkg::REG_W_RD;
                res_o.info.target_type = decode_pkg::TARGET_ABS;
                res_o.info.alu_grand_op = decode_pkg::ALU_GTYPE_LI;
                res_o.info.alu_op = `ALU_STYPE_PCPLUS4;
            end
            OP_B, OP_BL: begin
                res_o.info.reg_type_r0 = decode_pkg::REG_R0_NONE;
                res_o.info.reg_type_r1 = decode_pkg::REG_R1_NONE;
                res_o.info.addr_imm_type = decode_pkg::ADDR_IMM_S26;
                // BL links the return address into r1
                if (inst_i[26]) begin
                    res_o.info.reg_type_w = decode_pkg::REG_W_BL1;
                    res_o.info.alu_grand_op = decode_pkg::ALU_GTYPE_LI;
                    res_o.info.alu_op = `ALU_STYPE_PCPLUS4;
                end
            end
            OP_BEQ:  res_o.info.cmp_type = decode_pkg::CMP_E;
            OP_BNE:  res_o.info.cmp_type = decode_pkg::CMP_NE;
            OP_BLT:  res_o.info.cmp_type = decode_pkg::CMP_LT;
            OP_BGE:  res_o.info.cmp_type = decode_pkg::CMP_GE;
            OP_BLTU: res_o.info.cmp_type = decode_pkg::CMP_LTU;
            OP_BGEU: res_o.info.cmp_type = decode_pkg::CMP_GEU;
            default: res_o = '0;
        endcase
    end

    always_comb begin
        assert (!res_o.hit || res_o.info.jump_inst)
            else $error("branch_decode hit without jump_inst, inst %h", inst_i);
    end

endmodule

/* hw/decode_pkg.sv */
`include "decode_config.svh"

package decode_pkg;

    typedef logic [`INST_WIDTH-1:0]   inst_t;
    typedef logic [`ALU_OP_WIDTH-1:0] alu_op_t;

    // Source of operand 0
    typedef enum logic [1:0] {
        REG_R0_NONE,
        REG_R0_RD,
        REG_R0_RK,
        REG_R0_IMM
    } reg_r0_e;

    typedef enum logic {
        REG_R1_NONE,
        REG_R1_RJ
    } reg_r1_e;

    // BL1 writes the link register r1
    typedef enum logic [1:0] {
        REG_W_NONE,
        REG_W_RD,
        REG_W_BL1
    } reg_w_e;

    typedef enum logic [1:0] {IMM_U5, IMM_S12, IMM_U12, IMM_S20} imm_e;

    typedef enum logic [1:0] {ADDR_IMM_S26, ADDR_IMM_S16, ADDR_IMM_S12} addr_imm_e;

    typedef enum logic [1:0] {ALU_GTYPE_BW, ALU_GTYPE_LI, ALU_GTYPE_INT, ALU_GTYPE_SFT} alu_gtype_e;

    typedef enum logic [`CMP_WIDTH-1:0] {
        CMP_NOCOND,
        CMP_E,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_e;

    typedef enum logic {TARGET_REL, TARGET_ABS} target_e;

    typedef enum logic [`MEM_TYPE_WIDTH-1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_UBYTE,
        MEM_UHALF
    } mem_type_e;

    typedef struct packed {
        inst_t      inst;
        logic       alu_inst;
        logic       mul_inst;
        logic       div_inst;
        logic       lsu_inst;
        logic       jump_inst;
        logic       slot0;
        logic       mem_read;
        logic       mem_write;
        reg_r0_e    reg_type_r0;
        reg_r1_e    reg_type_r1;
        reg_w_e     reg_type_w;
        imm_e       imm_type;
        addr_imm_e  addr_imm_type;
        alu_gtype_e alu_grand_op;
        alu_op_t    alu_op;
        target_e    target_type;
        cmp_e       cmp_type;
        mem_type_e  mem_type;
    } decode_info_t;

    // All zero when the class does not own the opcode
    typedef struct packed {
        logic         hit;
        decode_info_t info;
    } class_decode_t;

    typedef enum logic {STAGE_IDLE, STAGE_ACK} stage_state_e;

endpackage

/* include/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Field widths
`define INST_WIDTH     32
`define ALU_OP_WIDTH   2
`define CMP_WIDTH      4
`define MEM_TYPE_WIDTH 3

// Bitwise group
`define ALU_STYPE_NOR     2'd0
`define ALU_STYPE_AND     2'd1
`define ALU_STYPE_OR      2'd2
`define ALU_STYPE_XOR     2'd3

// Load-immediate group
`define ALU_STYPE_LUI     2'd1
`define ALU_STYPE_PCADDUI 2'd2
`define ALU_STYPE_PCPLUS4 2'd3

// Integer group
`define ALU_STYPE_ADD     2'd0
`define ALU_STYPE_SUB     2'd1
`define ALU_STYPE_SLT     2'd2
`define ALU_STYPE_SLTU    2'd3

// Shift group
`define ALU_STYPE_SLL     2'd0
`define ALU_STYPE_SRL     2'd1
`define ALU_STYPE_SRA     2'd2

// Multiply and divide, carried in alu_op
`define MDU_TYPE_MULL     2'd0
`define MDU_TYPE_MULH     2'd1
`define MDU_TYPE_MULHU    2'd2
`define MDU_TYPE_DIV      2'd0
`define MDU_TYPE_MOD      2'd1
`define MDU_TYPE_DIVU     2'd2
`define MDU_TYPE_MODU     2'd3

`endif
